//--- flist.f
rtl/umi_pkg.sv
rtl/umi_ingress_stage.sv
rtl/umi_fanout_ctrl.sv
rtl/umi_stall_timer.sv
rtl/umi_router.sv
rtl/umi_fanout_top.sv
sim/umi_fanout_tb.sv

//--- Bender.yml
package:
  name: umi_fanout

sources:
  # design, package first
  - files:
      - rtl/umi_pkg.sv
      - rtl/umi_ingress_stage.sv
      - rtl/umi_fanout_ctrl.sv
      - rtl/umi_stall_timer.sv
      - rtl/umi_router.sv
      - rtl/umi_fanout_top.sv
  # testbench
  - target: simulation
    files:
      - sim/umi_fanout_tb.sv

//--- sim/umi_fanout_tb.sv
/*
 * Directed testbench for umi_fanout_top with M=4, STALL_LIMIT=16.
 * Inputs change on the rising edge and outputs are sampled on the falling edge.
 * Each wait is bounded by WAIT_MAX cycles.
 */
`timescale 1ns/100ps

module umi_fanout_tb
   import umi_pkg::*;
   ();

   localparam int M           = 4;
   localparam int STALL_LIMIT = 16;
   localparam int WAIT_MAX    = 100; // cycles per wait loop
   localparam int STREAM_N    = 24;  // packets in the in-order stream

   logic             clk;
   logic             rst_n;
   logic             umi_in_valid;
   umi_pkt_t         umi_in_pkt;
   logic             umi_in_ready;
   logic [M-1:0]     umi_out_valid;
   umi_pkt_t [M-1:0] umi_out_pkt;
   logic [M-1:0]     umi_out_ready;
   logic             drop_stall;
   logic             drop_badaddr;

   int       mismatches;
   int       timeouts;
   int       rx_port[$];   // sink log of the port per delivery
   umi_pkt_t rx_pkt[$];
   int       sent_port[$]; // expected order for the stream
   umi_pkt_t sent_pkt[$];

   umi_fanout_top #(.M(M), .STALL_LIMIT(STALL_LIMIT)) dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .umi_in_valid  (umi_in_valid),
      .umi_in_pkt    (umi_in_pkt),
      .umi_in_ready  (umi_in_ready),
      .umi_out_valid (umi_out_valid),
      .umi_out_pkt   (umi_out_pkt),
      .umi_out_ready (umi_out_ready),
      .drop_stall    (drop_stall),
      .drop_badaddr  (drop_badaddr)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk; // 4 ns period

   // port sinks log a delivery when all valid ports are ready together
   always @(negedge clk) begin
      if (rst_n && umi_out_valid != '0 && (&(~umi_out_valid | umi_out_ready))) begin
         for (int p = 0; p < M; p++) begin
            if (umi_out_valid[p]) begin
               rx_port.push_back(p);
               rx_pkt.push_back(umi_out_pkt[p]);
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [255:0] actual,
                              input logic [255:0] expected);
      if (actual !== expected) begin
         mismatches++;
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h (t=%0t)",
                  name, actual, expected, $time);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   // random packet with the port index forced and the opcode forced or kept off broadcast
   function automatic umi_pkt_t make_pkt(input int idx, input bit bcast);
      umi_pkt_t p;
      p.cmd     = $urandom;
      p.dstaddr = {$urandom, $urandom};
      p.srcaddr = {$urandom, $urandom};
      p.data    = {$urandom, $urandom};
      p.dstaddr[PORT_SEL_LSB +: PORT_SEL_W] = PORT_SEL_W'(idx);
      if (bcast) begin
         p.cmd[4:0] = UMI_OPC_BCAST;
      end else if (p.cmd[4:0] == UMI_OPC_BCAST) begin
         p.cmd[4:0] = 5'h01;
      end
      return p;
   endfunction

   // expected port select from opcode and dstaddr[47:40]
   function automatic logic [M-1:0] expect_sel(input umi_pkt_t p);
      int idx;
      idx = p.dstaddr[PORT_SEL_LSB +: PORT_SEL_W];
      if (p.cmd[4:0] == UMI_OPC_BCAST) return '1;
      if (idx >= M) return '0;
      return M'(1) << idx;
   endfunction

   // returns just after the transfer edge
   task automatic accept_pkt(input umi_pkt_t pkt);
      int waited;
      @(posedge clk);
      umi_in_valid <= 1'b1;
      umi_in_pkt   <= pkt;
      waited = 0;
      @(negedge clk);
      while (!umi_in_ready && waited < WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      if (!umi_in_ready) report_timeout("umi_in_ready stayed low, packet not accepted");
      @(posedge clk);
      umi_in_valid <= 1'b0;
   endtask

   // caller keeps port idx ready
   task automatic send_unicast(input int idx, output umi_pkt_t pkt);
      pkt = make_pkt(idx, 1'b0);
      accept_pkt(pkt);
      @(negedge clk); // one cycle after accept
      check_value("umi_out_valid", umi_out_valid, expect_sel(pkt));
      check_value($sformatf("umi_out_pkt[%0d]", idx), umi_out_pkt[idx], pkt);
      @(negedge clk); // delivered on the edge between
      check_value("umi_in_ready", umi_in_ready, 1'b1);
      check_value("umi_out_valid", umi_out_valid, '0);
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      check_value("umi_out_valid", umi_out_valid, '0);
      check_value("drop_stall", drop_stall, 1'b0);
      check_value("drop_badaddr", drop_badaddr, 1'b0);
      check_value("umi_in_ready", umi_in_ready, 1'b1);
   endtask

   task automatic route_each_port();
      umi_pkt_t pkt;
      for (int i = 0; i < M; i++) send_unicast(i, pkt);
   endtask

   task automatic broadcast_with_backpressure();
      umi_pkt_t pkt;
      int       waited;
      bit       delivered;
      for (int n = 0; n < 3; n++) begin
         pkt = make_pkt($urandom_range(255, 0), 1'b1); // index ignored
         accept_pkt(pkt);
         umi_out_ready <= M'($urandom);
         waited    = 0;
         delivered = 1'b0;
         while (!delivered && waited < WAIT_MAX) begin
            @(negedge clk);
            check_value("umi_out_valid", umi_out_valid, {M{1'b1}});
            check_value("umi_in_ready", umi_in_ready, 1'b0);
            for (int p = 0; p < M; p++) begin
               check_value($sformatf("umi_out_pkt[%0d]", p), umi_out_pkt[p], pkt);
            end
            delivered = (umi_out_ready == '1);
            @(posedge clk);
            waited++;
            // all ready forced well before the stall limit
            umi_out_ready <= (waited >= 8) ? '1 : M'($urandom);
         end
         if (!delivered) report_timeout("broadcast packet never saw all ports ready");
         @(negedge clk);
         check_value("umi_in_ready", umi_in_ready, 1'b1);
         check_value("umi_out_valid", umi_out_valid, '0);
      end
      @(posedge clk);
      umi_out_ready <= '1;
   endtask

   task automatic drop_bad_address();
      umi_pkt_t pkt;
      int       waited;
      pkt = make_pkt($urandom_range(255, M), 1'b0);
      accept_pkt(pkt);
      waited = 0;
      @(negedge clk);
      while (!drop_badaddr && waited < WAIT_MAX) begin
         check_value("umi_out_valid", umi_out_valid, '0);
         @(negedge clk);
         waited++;
      end
      if (!drop_badaddr) begin
         report_timeout("drop_badaddr never pulsed for an out-of-range port index");
      end else begin
         check_value("umi_out_valid", umi_out_valid, '0);
         check_value("drop_stall", drop_stall, 1'b0);
         @(negedge clk); // single pulse only
         check_value("drop_badaddr", drop_badaddr, 1'b0);
         check_value("umi_in_ready", umi_in_ready, 1'b1);
      end
      send_unicast($urandom_range(M - 1, 0), pkt); // next one goes through
   endtask

   task automatic drop_on_stall();
      umi_pkt_t pkt;
      int       stalled;
      bit       seen;
      @(posedge clk);
      umi_out_ready <= 4'b1110; // port 0 blocked
      pkt = make_pkt(0, 1'b0);
      accept_pkt(pkt);
      stalled = 0;
      seen    = 1'b0;
      while (!seen && stalled <= WAIT_MAX) begin
         @(negedge clk);
         if (drop_stall) begin
            seen = 1'b1;
         end else begin
            check_value("umi_out_valid", umi_out_valid, 4'b0001);
            check_value("umi_out_pkt[0]", umi_out_pkt[0], pkt);
            stalled++;
         end
      end
      if (!seen) begin
         report_timeout("drop_stall never pulsed with port 0 held not ready");
      end else begin
         check_value("stalled cycles", stalled, STALL_LIMIT);
         check_value("umi_out_valid", umi_out_valid, '0);
         check_value("drop_badaddr", drop_badaddr, 1'b0);
         @(negedge clk);
         check_value("drop_stall", drop_stall, 1'b0);
         check_value("umi_in_ready", umi_in_ready, 1'b1);
      end
      // port 0 still blocked while the others deliver
      send_unicast(2, pkt);
      send_unicast(3, pkt);
      @(posedge clk);
      umi_out_ready <= '1;
   endtask

   task automatic stream_in_order();
      umi_pkt_t pkt;
      int       idx;
      int       waited;
      rx_port.delete();
      rx_pkt.delete();
      for (int n = 0; n < STREAM_N; n++) begin
         idx = $urandom_range(M - 1, 0);
         send_unicast(idx, pkt);
         sent_port.push_back(idx);
         sent_pkt.push_back(pkt);
      end
      waited = 0;
      while (rx_pkt.size() < STREAM_N && waited < WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      if (rx_pkt.size() < STREAM_N) report_timeout("stream packets missing at the sinks");
      check_value("delivered packet count", rx_pkt.size(), STREAM_N);
      for (int n = 0; n < STREAM_N && n < rx_pkt.size(); n++) begin
         check_value($sformatf("rx_port[%0d]", n), rx_port[n], sent_port[n]);
         check_value($sformatf("rx_pkt[%0d]", n), rx_pkt[n], sent_pkt[n]);
      end
   endtask

   initial begin
      void'($urandom(87514));
      mismatches    = 0;
      timeouts      = 0;
      rst_n         = 1'b0;
      umi_in_valid  = 1'b0;
      umi_in_pkt    = '0;
      umi_out_ready = '1;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      route_each_port();
      broadcast_with_backpressure();
      drop_bad_address();
      drop_on_stall();
      stream_in_order();
      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- rtl/umi_fanout_top.sv
/*
 * UMI address-routed fanout, one packet held at a time.
 * Port picked by dstaddr[47:40], broadcast opcode goes to all M ports.
 * Packet delivered only when all selected ports are ready together.
 * Drops reported on drop_stall and drop_badaddr, one cycle each.
 */
`timescale 1ns/100ps

module umi_fanout_top
   import umi_pkg::*;
   #(
   parameter int M           = 4,  // output ports, 1 to 256
   parameter int STALL_LIMIT = 16  // stalled cycles before drop
   )
   (
   input  logic                 clk,
   input  logic                 rst_n,
   // inbound
   input  logic                 umi_in_valid,
   input  umi_pkt_t             umi_in_pkt,
   output logic                 umi_in_ready,
   // outbound, one lane per port
   output logic     [M-1:0]     umi_out_valid,
   output umi_pkt_t [M-1:0]     umi_out_pkt,
   input  logic     [M-1:0]     umi_out_ready,
   // status pulses
   output logic                 drop_stall,
   output logic                 drop_badaddr
   );

   logic         load;
   umi_pkt_t     hold_pkt;
   logic [M-1:0] hold_sel;
   logic         send;
   logic         route_ready;
   logic         timer_run;
   logic         stall_expired;

   umi_ingress_stage #(.M(M)) ingress0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load),
      .in_pkt   (umi_in_pkt),
      .hold_pkt (hold_pkt),
      .hold_sel (hold_sel)
   );

   umi_fanout_ctrl #(.M(M)) ctrl0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (umi_in_valid),
      .in_ready      (umi_in_ready),
      .load          (load),
      .hold_sel      (hold_sel),
      .route_ready   (route_ready),
      .send          (send),
      .timer_run     (timer_run),
      .stall_expired (stall_expired),
      .drop_stall    (drop_stall),
      .drop_badaddr  (drop_badaddr)
   );

   umi_stall_timer #(.STALL_LIMIT(STALL_LIMIT)) timer0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .timer_run     (timer_run),
      .stall_expired (stall_expired)
   );

   umi_router #(.M(M)) router0 (
      .send        (send),
      .hold_pkt    (hold_pkt),
      .hold_sel    (hold_sel),
      .out_valid   (umi_out_valid),
      .out_pkt     (umi_out_pkt),
      .out_ready   (umi_out_ready),
      .route_ready (route_ready)
   );

endmodule

//--- rtl/umi_router.sv
/*
 * Combinational fanout of one packet to M ports.
 * Every port sees the same packet, valid only where selected.
 * Ready is the AND of all valid ports, no per-port service.
 */
`timescale 1ns/100ps

module umi_router
   import umi_pkg::*;
   #(
   parameter int M = 4 // number of output ports
   )
   (
   input  logic                 send,       // controller in FS_SEND
   input  umi_pkt_t             hold_pkt,
   input  logic     [M-1:0]     hold_sel,
   output logic     [M-1:0]     out_valid,
   output umi_pkt_t [M-1:0]     out_pkt,
   input  logic     [M-1:0]     out_ready,
   output logic                 route_ready // all valid ports ready
   );

   assign out_valid = send ? hold_sel : '0;

   // same packet on every port
   assign out_pkt = {M{hold_pkt}};

   // unselected ports never block
   assign route_ready = &(~out_valid | out_ready);

endmodule

//--- rtl/umi_stall_timer.sv
/*
 * Stall cycle counter, restarts whenever timer_run drops.
 * stall_expired rises on the STALL_LIMIT-th consecutive stalled cycle.
 * STALL_LIMIT must be 1 or more.
 */
`timescale 1ns/100ps

module umi_stall_timer
   #(
   parameter int STALL_LIMIT = 16 // stalled cycles before drop
   )
   (
   input  logic clk,
   input  logic rst_n,
   input  logic timer_run,    // send active, route not ready
   output logic stall_expired
   );

   localparam int CNT_W = (STALL_LIMIT > 1) ? $clog2(STALL_LIMIT) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STALL_LIMIT - 1);

   logic [CNT_W-1:0] cnt;

   assign stall_expired = timer_run & (cnt == CNT_LAST);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (!timer_run) begin
         cnt <= '0;           // fresh start per packet
      end else if (cnt != CNT_LAST) begin
         cnt <= cnt + 1'b1;   // hold at limit
      end
   end

endmodule

//--- rtl/umi_fanout_ctrl.sv
/*
 * Accept / send / drop sequencer, one packet in flight.
 * in_ready high only in FS_IDLE, so best case is one packet per two cycles.
 * Empty select goes to FS_DROP from FS_SEND without raising any valid.
 * Drop pulses last exactly the one FS_DROP cycle.
 */
`timescale 1ns/100ps

module umi_fanout_ctrl
   import umi_pkg::*;
   #(
   parameter int M = 4 // number of output ports
   )
   (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         in_valid,
   output logic         in_ready,
   output logic         load,          // capture strobe to ingress stage
   input  logic [M-1:0] hold_sel,
   input  logic         route_ready,   // all selected ports ready
   output logic         send,          // gates router valids
   output logic         timer_run,     // stalled send cycle
   input  logic         stall_expired,
   output logic         drop_stall,
   output logic         drop_badaddr
   );

   fanout_state_e state;
   fanout_state_e state_nxt;
   logic          sel_any;
   logic          drop_is_stall; // reason for the current FS_DROP

   assign sel_any   = |hold_sel;
   assign in_ready  = (state == FS_IDLE);
   assign load      = in_ready & in_valid;  // accept edge
   assign send      = (state == FS_SEND) & sel_any;
   assign timer_run = send & ~route_ready;

   // pulses straight from state, reason picks which one
   assign drop_stall   = (state == FS_DROP) & drop_is_stall;
   assign drop_badaddr = (state == FS_DROP) & ~drop_is_stall;

   always_comb begin
      state_nxt = state;
      case (state)
         FS_IDLE: begin
            if (load) state_nxt = FS_SEND;
         end
         FS_SEND: begin
            if (!sel_any) begin
               state_nxt = FS_DROP;     // nowhere to go
            end else if (route_ready) begin
               state_nxt = FS_IDLE;     // delivered this edge
            end else if (stall_expired) begin
               state_nxt = FS_DROP;     // waited too long
            end
         end
         FS_DROP: state_nxt = FS_IDLE;
         default: state_nxt = FS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state         <= FS_IDLE;
         drop_is_stall <= 1'b0;
      end else begin
         state <= state_nxt;
         // latch reason on the way into FS_DROP
         if (state == FS_SEND && state_nxt == FS_DROP) begin
            drop_is_stall <= sel_any;
         end
      end
   end

endmodule

//--- rtl/umi_ingress_stage.sv
/*
 * Single-entry packet holding register with port decode.
 * Broadcast opcode selects all M ports.
 * Index of M or more decodes to an empty select (bad address).
 * Packet and select change only on load.
 */
`timescale 1ns/100ps

module umi_ingress_stage
   import umi_pkg::*;
   #(
   parameter int M = 4 // number of output ports, 1 to 256
   )
   (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load,     // accept strobe from controller
   input  umi_pkt_t     in_pkt,
   output umi_pkt_t     hold_pkt, // packet under delivery
   output logic [M-1:0] hold_sel  // one-hot, all ones or zero
   );

   umi_opc_t      opc;
   umi_port_idx_t port_idx;
   logic [M-1:0]  sel_dec;

   assign opc      = in_pkt.cmd[UMI_OPC_W-1:0];
   assign port_idx = in_pkt.dstaddr[PORT_SEL_LSB +: PORT_SEL_W];

   // decode on the input side so select lands with the packet
   always_comb begin
      sel_dec = '0;
      if (opc == UMI_OPC_BCAST) begin
         sel_dec = '1; // every port
      end else begin
         for (int i = 0; i < M; i++) begin
            // index >= M never matches, leaves zero
            sel_dec[i] = (port_idx == umi_port_idx_t'(i));
         end
      end
   end

   // select is control, cleared in reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hold_sel <= '0;
      end else if (load) begin
         hold_sel <= sel_dec;
      end
   end

   // payload only, no reset
   always_ff @(posedge clk) begin
      if (load) begin
         hold_pkt <= in_pkt;
      end
   end

endmodule

//--- rtl/umi_pkg.sv
/*
 * Fixed UMI width set shared by the fanout subsystem.
 * Port index field sits in dstaddr[47:40], so at most 256 ports.
 * Opcode is the low 5 bits of cmd. Other cmd fields are not decoded.
 */
package umi_pkg;

   localparam int UMI_CW = 32;     // command width
   localparam int UMI_AW = 64;     // address width
   localparam int UMI_DW = 64;     // payload width
   localparam int UMI_OPC_W = 5;   // opcode field in cmd

   // destination address field that picks the output port
   localparam int PORT_SEL_LSB = 40;
   localparam int PORT_SEL_W = 8;

   typedef logic [UMI_CW-1:0] umi_cmd_t;
   typedef logic [UMI_AW-1:0] umi_addr_t;
   typedef logic [UMI_DW-1:0] umi_data_t;
   typedef logic [UMI_OPC_W-1:0] umi_opc_t;
   typedef logic [PORT_SEL_W-1:0] umi_port_idx_t;

   // deliver to every port, address index ignored
   localparam umi_opc_t UMI_OPC_BCAST = 5'h0F;

   // whole packet, 224 bits, cmd in the top bits
   typedef struct packed {
      umi_cmd_t  cmd;
      umi_addr_t dstaddr;
      umi_addr_t srcaddr;
      umi_data_t data;
   } umi_pkt_t;

   // controller sequencing
   typedef enum logic [1:0] {
      FS_IDLE = 2'd0, // ready for a new packet
      FS_SEND = 2'd1, // valids up, waiting on all selected ports
      FS_DROP = 2'd2  // one cycle, drop pulse out
   } fanout_state_e;

endpackage
